// File: rtl/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Layer dimensions
`define CONV_CH_IN        4
`define CONV_CH_OUT       2
`define CONV_IMAGE_SIZE   16

// Arithmetic widths
`define CONV_DATA_WIDTH   16
`define CONV_ACC_WIDTH    40
`define CONV_FRAC_BITS    8

// Alignment FIFO
`define CONV_FIFO_DEPTH   32
`define CONV_START_LEVEL  8

`endif

// File: rtl/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

	// Signed pixel, also used for weights
	typedef logic signed [`CONV_DATA_WIDTH-1:0] pixel_t;

	// Dot product accumulator, wide enough for CH_IN products
	typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

	// Index = out_channel * CH_IN + in_channel
	typedef pixel_t [`CONV_CH_IN*`CONV_CH_OUT-1:0] weight_array_t;

	// Counters
	typedef logic [$clog2(`CONV_CH_IN)-1:0] ch_in_t;
	typedef logic [$clog2(`CONV_CH_OUT)-1:0] ch_out_t;
	typedef logic [$clog2(`CONV_IMAGE_SIZE)-1:0] pos_t;
	typedef logic [$clog2(`CONV_FIFO_DEPTH+1)-1:0] level_t;

endpackage

// File: rtl/conv_if.sv
`timescale 1ns/1ps

// Result stream from the MAC into the alignment FIFO
interface conv_result_if;
	logic             valid;
	conv_pkg::pixel_t data;
	logic             last;
	logic             full;

	modport producer (output valid, output data, output last, input full);
	modport consumer (input valid, input data, input last, output full);
endinterface

// FIFO read side, data registered one cycle after rd_en
interface conv_fifo_rd_if;
	logic              rd_en;
	conv_pkg::pixel_t  data;
	logic              last;
	logic              empty;
	conv_pkg::level_t  level;

	modport fifo (input rd_en, output data, output last, output empty, output level);
	modport reader (output rd_en, input data, input last, input empty, input level);
endinterface

// File: rtl/conv_weight_bank.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_weight_bank (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    valid_weight_in,
	input  conv_pkg::pixel_t        weight_in,
	output conv_pkg::weight_array_t weights
);

	localparam int NUM_WEIGHTS = `CONV_CH_IN * `CONV_CH_OUT;
	localparam int IDX_WIDTH = $clog2(NUM_WEIGHTS);

	logic [IDX_WIDTH-1:0] wr_idx;

	////////////////////////////////////////////////////////////
	// Write index, out-major order
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_idx <= '0;
		end else if (valid_weight_in) begin
			if (wr_idx == IDX_WIDTH'(NUM_WEIGHTS - 1)) begin
				wr_idx <= '0;
			end else begin
				wr_idx <= wr_idx + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Weight storage
	////////////////////////////////////////////////////////////

	// All weights visible in parallel to the MAC
	always_ff @(posedge clk) begin
		if (valid_weight_in) begin
			weights[wr_idx] <= weight_in;
		end
	end

endmodule

// File: rtl/conv_channel_mac.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_channel_mac (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    valid_in,
	input  conv_pkg::pixel_t        pxl_in,
	input  conv_pkg::weight_array_t weights,
	conv_result_if.producer         res
);

	// Saturation limits of the output pixel
	localparam conv_pkg::acc_t SAT_MAX =
		(conv_pkg::acc_t'(1) <<< (`CONV_DATA_WIDTH - 1)) - conv_pkg::acc_t'(1);
	localparam conv_pkg::acc_t SAT_MIN = -SAT_MAX - conv_pkg::acc_t'(1);

	conv_pkg::ch_in_t  ch_cnt;
	conv_pkg::ch_out_t emit_cnt;
	conv_pkg::pos_t    pos_cnt;
	logic              emit_active;
	logic              emit_last;
	logic              group_end;
	conv_pkg::acc_t    acc      [`CONV_CH_OUT];
	conv_pkg::acc_t    acc_next [`CONV_CH_OUT];
	conv_pkg::pixel_t  result_q [`CONV_CH_OUT];

	// Arithmetic shift then clamp to the pixel range
	function automatic conv_pkg::pixel_t requant(input conv_pkg::acc_t sum);
		conv_pkg::acc_t shifted;
		shifted = sum >>> `CONV_FRAC_BITS;
		if (shifted > SAT_MAX) begin
			return conv_pkg::pixel_t'(SAT_MAX);
		end else if (shifted < SAT_MIN) begin
			return conv_pkg::pixel_t'(SAT_MIN);
		end
		return conv_pkg::pixel_t'(shifted);
	endfunction

	assign group_end = valid_in && (ch_cnt == conv_pkg::ch_in_t'(`CONV_CH_IN - 1));
	assign emit_last = (emit_cnt == conv_pkg::ch_out_t'(`CONV_CH_OUT - 1));

	////////////////////////////////////////////////////////////
	// Accumulation, all output channels in parallel
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int o = 0; o < `CONV_CH_OUT; o++) begin
			acc_next[o] = pxl_in * $signed(weights[o * `CONV_CH_IN + int'(ch_cnt)]);
			// First channel of a group loads instead of adding
			if (ch_cnt != '0) begin
				acc_next[o] = acc_next[o] + acc[o];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < `CONV_CH_OUT; o++) begin
			if (valid_in) begin
				acc[o] <= acc_next[o];
			end
			if (group_end) begin
				result_q[o] <= requant(acc_next[o]);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Channel, emission and position counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ch_cnt      <= '0;
			emit_cnt    <= '0;
			pos_cnt     <= '0;
			emit_active <= 1'b0;
		end else begin
			if (valid_in) begin
				ch_cnt <= group_end ? '0 : ch_cnt + 1'b1;
			end
			if (group_end) begin
				emit_active <= 1'b1;
				emit_cnt    <= '0;
			end else if (emit_active) begin
				emit_active <= !emit_last;
				emit_cnt    <= emit_last ? '0 : emit_cnt + 1'b1;
			end
			if (emit_active && emit_last) begin
				pos_cnt <= (pos_cnt == conv_pkg::pos_t'(`CONV_IMAGE_SIZE - 1)) ?
					'0 : pos_cnt + 1'b1;
			end
		end
	end

	assign res.valid = emit_active;
	assign res.data  = result_q[emit_cnt];
	assign res.last  = emit_active && emit_last &&
		(pos_cnt == conv_pkg::pos_t'(`CONV_IMAGE_SIZE - 1));

endmodule

// File: rtl/conv_align_fifo.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_align_fifo (
	input  logic            clk,
	input  logic            reset,
	conv_result_if.consumer wr,
	conv_fifo_rd_if.fifo    rd
);

	localparam int PTR_WIDTH = $clog2(`CONV_FIFO_DEPTH);

	conv_pkg::pixel_t     data_mem [`CONV_FIFO_DEPTH];
	logic                 last_mem [`CONV_FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	conv_pkg::level_t     level;
	logic                 do_wr;
	logic                 do_rd;

	function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(`CONV_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign rd.empty = (level == '0);
	assign rd.level = level;
	assign wr.full  = (level == conv_pkg::level_t'(`CONV_FIFO_DEPTH));

	assign do_wr = wr.valid && !wr.full;
	assign do_rd = rd.rd_en && !rd.empty;

	// Storage and registered read port
	always_ff @(posedge clk) begin
		if (do_wr) begin
			data_mem[wr_ptr] <= wr.data;
			last_mem[wr_ptr] <= wr.last;
		end
		if (do_rd) begin
			rd.data <= data_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level   <= '0;
			rd.last <= 1'b0;
		end else begin
			if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
			if (do_wr && !do_rd) begin
				level <= level + 1'b1;
			end else if (do_rd && !do_wr) begin
				level <= level - 1'b1;
			end
			// Last flag only marks the cycle of its read data
			rd.last <= do_rd && last_mem[rd_ptr];
		end
	end

endmodule

// File: rtl/conv_output_align.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_output_align (
	input  logic             clk,
	input  logic             reset,
	conv_fifo_rd_if.reader   rd,
	output conv_pkg::pixel_t pxl_out,
	output logic             valid_out,
	output logic             last_out
);

	logic started;

	////////////////////////////////////////////////////////////
	// Start once enough results are buffered, then drain
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
		end else if (rd.level >= conv_pkg::level_t'(`CONV_START_LEVEL)) begin
			started <= 1'b1;
		end
	end

	assign rd.rd_en = started && !rd.empty;

	// Strobe lines up with the registered FIFO data
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= rd.rd_en;
		end
	end

	assign pxl_out  = rd.data;
	assign last_out = rd.last;

endmodule

// File: rtl/conv_1x1_layer.sv
`timescale 1ns/1ps

module conv_1x1_layer (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	input  conv_pkg::pixel_t pxl_in,
	input  logic             valid_weight_in,
	input  conv_pkg::pixel_t weight_in,
	output conv_pkg::pixel_t pxl_out,
	output logic             valid_out,
	output logic             last_out
);

	conv_pkg::weight_array_t weights;

	conv_result_if  result_bus ();
	conv_fifo_rd_if fifo_rd_bus ();

	////////////////////////////////////////////////////////////
	// Weights and dot products
	////////////////////////////////////////////////////////////

	conv_weight_bank conv_weight_bank_inst (
		.clk             (clk),
		.reset           (reset),
		.valid_weight_in (valid_weight_in),
		.weight_in       (weight_in),
		.weights         (weights)
	);

	conv_channel_mac conv_channel_mac_inst (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pxl_in   (pxl_in),
		.weights  (weights),
		.res      (result_bus.producer)
	);

	////////////////////////////////////////////////////////////
	// Output alignment
	////////////////////////////////////////////////////////////

	conv_align_fifo conv_align_fifo_inst (
		.clk   (clk),
		.reset (reset),
		.wr    (result_bus.consumer),
		.rd    (fifo_rd_bus.fifo)
	);

	conv_output_align conv_output_align_inst (
		.clk       (clk),
		.reset     (reset),
		.rd        (fifo_rd_bus.reader),
		.pxl_out   (pxl_out),
		.valid_out (valid_out),
		.last_out  (last_out)
	);

endmodule

// File: test/conv_1x1_layer_assert.sv
`timescale 1ns/1ps

module conv_1x1_layer_assert (
	input logic clk,
	input logic reset,
	input logic wr_valid,
	input logic wr_full,
	input logic rd_en,
	input logic valid_out,
	input logic last_out
);

	// Results stored in and taken out of the FIFO so far
	int unsigned writes_done;
	int unsigned reads_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			writes_done <= 0;
			reads_done  <= 0;
		end else begin
			if (wr_valid && !wr_full) begin
				writes_done <= writes_done + 1;
			end
			if (rd_en) begin
				reads_done <= reads_done + 1;
			end
		end
	end

	// FIFO never overflows
	no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		!(wr_valid && wr_full))
		else $error("alignment FIFO written while full");

	last_with_valid: assert property (@(posedge clk) disable iff (reset)
		last_out |-> valid_out)
		else $error("last_out without valid_out");

	// Output strobe held low while in reset
	quiet_in_reset: assert property (@(posedge clk) reset |=> !valid_out)
		else $error("valid_out high during reset");

	// A read needs a result stored in an earlier cycle
	no_read_when_empty: assert property (@(posedge clk) disable iff (reset)
		rd_en |-> (reads_done < writes_done))
		else $error("alignment FIFO read while empty");

endmodule

bind conv_1x1_layer conv_1x1_layer_assert conv_1x1_layer_assert_inst (
	.clk       (clk),
	.reset     (reset),
	.wr_valid  (result_bus.valid),
	.wr_full   (result_bus.full),
	.rd_en     (fifo_rd_bus.rd_en),
	.valid_out (valid_out),
	.last_out  (last_out)
);

// File: test/conv_1x1_layer_tb.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_1x1_layer_tb;

	localparam int CH_IN = `CONV_CH_IN;
	localparam int CH_OUT = `CONV_CH_OUT;
	localparam int IMAGE_SIZE = `CONV_IMAGE_SIZE;
	// Three frames of 64 strobes at up to three cycles each, plus loads, drain and margin
	localparam int TIMEOUT_CYCLES = 3000;

	logic             clk;
	logic             reset;
	logic             valid_in;
	conv_pkg::pixel_t pxl_in;
	logic             valid_weight_in;
	conv_pkg::pixel_t weight_in;
	conv_pkg::pixel_t pxl_out;
	logic             valid_out;
	logic             last_out;

	logic [15:0] lfsr_state = 16'd1;
	int          px_tb [CH_IN];
	int          w_tb [CH_OUT][CH_IN];
	int          exp_data_q [$];
	bit          exp_last_q [$];
	string       exp_name_q [$];
	int          pushed_total = 0;
	int          cycle_count = 0;
	string       cmp_name;
	int          cmp_data;
	bit          cmp_last;

	conv_1x1_layer conv_1x1_layer_inst (
		.clk             (clk),
		.reset           (reset),
		.valid_in        (valid_in),
		.pxl_in          (pxl_in),
		.valid_weight_in (valid_weight_in),
		.weight_in       (weight_in),
		.pxl_out         (pxl_out),
		.valid_out       (valid_out),
		.last_out        (last_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Random numbers and reference model
	////////////////////////////////////////////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int rand_signed(input int n);
		int v;
		v = int'(rand_bits(n));
		if (v >= (1 << (n - 1))) begin
			v = v - (1 << n);
		end
		return v;
	endfunction

	// Dot product of one position, shifted and clamped to 16 bits
	function automatic int ref_output(input int o);
		longint sum;
		sum = 0;
		for (int c = 0; c < CH_IN; c++) begin
			sum = sum + longint'(px_tb[c]) * longint'(w_tb[o][c]);
		end
		sum = sum >>> `CONV_FRAC_BITS;
		if (sum > 32767) return 32767;
		if (sum < -32768) return -32768;
		return int'(sum);
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "check failed");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Mode 0 small random, 1 saturating, 2 wider random
	task automatic load_weights(input int mode);
		for (int o = 0; o < CH_OUT; o++) begin
			for (int c = 0; c < CH_IN; c++) begin
				if (mode == 0) w_tb[o][c] = rand_signed(8);
				else if (mode == 1) w_tb[o][c] = (o == 0) ? 32767 : -32768;
				else w_tb[o][c] = rand_signed(10);
				@(negedge clk);
				valid_weight_in = 1'b1;
				weight_in = conv_pkg::pixel_t'(w_tb[o][c]);
			end
		end
		@(negedge clk);
		valid_weight_in = 1'b0;
	endtask

	task automatic send_pixel(input int value, input int gap);
		@(negedge clk);
		valid_in = 1'b1;
		pxl_in = conv_pkg::pixel_t'(value);
		repeat (gap) begin
			@(negedge clk);
			valid_in = 1'b0;
		end
	endtask

	task automatic run_frame(input string name, input int mode);
		for (int pos = 0; pos < IMAGE_SIZE; pos++) begin
			for (int c = 0; c < CH_IN; c++) begin
				if (mode == 0) px_tb[c] = rand_signed(8);
				else if (mode == 1) px_tb[c] = (pos % 2 == 0) ? 32767 : -32768;
				else px_tb[c] = rand_signed(12);
				send_pixel(px_tb[c], (mode == 2) ? int'(rand_bits(1)) + 1 : 0);
			end
			for (int o = 0; o < CH_OUT; o++) begin
				exp_data_q.push_back(ref_output(o));
				exp_last_q.push_back(pos == IMAGE_SIZE - 1 && o == CH_OUT - 1);
				exp_name_q.push_back(name);
				pushed_total++;
			end
		end
		@(negedge clk);
		valid_in = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Compare and timeout
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset && valid_out) begin
			if (exp_data_q.size() == 0) begin
				$display("valid_out asserted with no expected result pending");
				$display("ERRORS FOUND");
				$fatal(1, "unexpected output");
			end else if (pushed_total < `CONV_START_LEVEL) begin
				$display("valid_out appeared before the start level of results was due");
				$display("ERRORS FOUND");
				$fatal(1, "early output");
			end else begin
				cmp_name = exp_name_q.pop_front();
				cmp_data = exp_data_q.pop_front();
				cmp_last = exp_last_q.pop_front();
				check_value({cmp_name, " pxl_out"}, cmp_data, int'(pxl_out));
				check_value({cmp_name, " last_out"}, int'(cmp_last), int'(last_out));
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, outputs still missing", cycle_count);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	initial begin
		reset = 1'b1;
		valid_in = 1'b0;
		pxl_in = '0;
		valid_weight_in = 1'b0;
		weight_in = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		load_weights(0);
		run_frame("random_small", 0);
		// New weights for each following frame
		load_weights(1);
		run_frame("saturation", 1);
		load_weights(2);
		run_frame("random_gaps", 2);
		while (exp_data_q.size() != 0) @(negedge clk);
		repeat (4) @(negedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: conv_1x1_layer.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_if.sv
rtl/conv_weight_bank.sv
rtl/conv_channel_mac.sv
rtl/conv_align_fifo.sv
rtl/conv_output_align.sv
rtl/conv_1x1_layer.sv
test/conv_1x1_layer_assert.sv
test/conv_1x1_layer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f conv_1x1_layer.f \
	--top-module conv_1x1_layer_tb \
	--Mdir obj_dir -o conv_1x1_layer_tb

sim_status=0
sim_output=$(./obj_dir/conv_1x1_layer_tb 2>&1) || sim_status=$?
echo "$sim_output"

if [ "$sim_status" -eq 0 ] && grep -qx "NO ERRORS" <<< "$sim_output"; then
	exit 0
fi
exit 1
